//--- csr_map_pkg.sv
/*
 * CSR address map for the machine-mode CSR unit
 * Standard addresses, counter block decode constants, operation codes,
 * internal register select codes and the address view union.
 */

`default_nettype none

package csr_map_pkg;

  // named machine-mode registers
  localparam logic [11:0] CSR_MSTATUS       = 12'h300;
  localparam logic [11:0] CSR_MISA          = 12'h301;
  localparam logic [11:0] CSR_MSCRATCH      = 12'h340;
  localparam logic [11:0] CSR_MEPC          = 12'h341;
  localparam logic [11:0] CSR_MCAUSE        = 12'h342;
  localparam logic [11:0] CSR_MTVAL         = 12'h343;
  localparam logic [11:0] CSR_MHARTID       = 12'hF14;
  localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;
  localparam logic [11:0] CSR_MCYCLE        = 12'hB00;
  localparam logic [11:0] CSR_MCYCLEH       = 12'hB80;
  localparam logic [11:0] CSR_MINSTRET      = 12'hB02;
  localparam logic [11:0] CSR_MINSTRETH     = 12'hB82;

  // counter blocks, 32 slots each
  localparam logic [11:0] CSR_OFF_MCOUNTER  = 12'hB00;
  localparam logic [11:0] CSR_OFF_MCOUNTERH = 12'hB80;
  localparam logic [11:0] CSR_MASK_MCOUNTER = 12'hFE0;

  localparam logic [1:0] CSR_OP_READ  = 2'd0;
  localparam logic [1:0] CSR_OP_WRITE = 2'd1;
  localparam logic [1:0] CSR_OP_SET   = 2'd2;
  localparam logic [1:0] CSR_OP_CLEAR = 2'd3;

  // register select from decode to the execute and result stages
  localparam logic [3:0] SEL_NONE     = 4'd0;
  localparam logic [3:0] SEL_MSTATUS  = 4'd1;
  localparam logic [3:0] SEL_MISA     = 4'd2;
  localparam logic [3:0] SEL_MSCRATCH = 4'd3;
  localparam logic [3:0] SEL_MEPC     = 4'd4;
  localparam logic [3:0] SEL_MCAUSE   = 4'd5;
  localparam logic [3:0] SEL_MTVAL    = 4'd6;
  localparam logic [3:0] SEL_MHARTID  = 4'd7;
  localparam logic [3:0] SEL_INHIBIT  = 4'd8;
  localparam logic [3:0] SEL_COUNTER  = 4'd9;

  // address seen as a raw value or as its privileged-spec fields
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      logic [1:0] access;
      logic [1:0] priv;
      logic [2:0] group;
      logic [4:0] index;
    } f;
  } csr_addr_u;

endpackage

`default_nettype wire

//--- csr_field_pkg.sv
/*
 * CSR field layout for the machine-mode CSR unit
 * Data width, mstatus and mcause field positions, the misa constant
 * and the slot layout of the performance counter array.
 */

`default_nettype none

package csr_field_pkg;

  localparam int unsigned XLEN = 32;

  // mstatus, MPP is hardwired to machine mode
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;

  // stored cause: interrupt flag on top, 5-bit code below
  localparam int unsigned MCAUSE_W = 6;

  // RV32I with C and X, MXL = 1
  localparam logic [31:0] MISA_VALUE =
      (32'd1 << 2)  |
      (32'd1 << 8)  |
      (32'd1 << 23) |
      (32'd1 << 30);

  ////////////////////////////////////////////////////////////////////////////
  // counter array
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned CNT_SLOTS = 32;
  // mcycle, reserved time slot, minstret
  localparam int unsigned CNT_FIXED = 3;
  localparam int unsigned CNT_FULL_W = 64;

endpackage

`default_nettype wire

//--- csr_decode.sv
/*
 * CSR address decode
 * Maps the 12-bit CSR address to an internal register select and a
 * counter slot, and flags unimplemented addresses and writes to
 * read-only registers. Unused counter slots decode as legal but empty.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_decode #(
  parameter int unsigned MHPM_COUNTER_NUM = 4
) (
  input  wire logic        csr_access_i,
  input  wire logic [11:0] csr_addr_i,
  input  wire logic [1:0]  csr_op_i,
  output logic      [3:0]  reg_sel_o,
  output logic      [4:0]  cnt_idx_o,
  output logic             cnt_hi_o,
  output logic             wr_en_o,
  output logic             illegal_o
);

  localparam int unsigned CNT_LAST = csr_field_pkg::CNT_FIXED + MHPM_COUNTER_NUM;

  csr_map_pkg::csr_addr_u addr;
  logic                   in_cnt_lo;
  logic                   in_cnt_hi;
  logic                   known;
  logic                   ro_write;
  logic                   is_write;

  assign addr.raw = csr_addr_i;

  assign in_cnt_lo = (addr.raw & csr_map_pkg::CSR_MASK_MCOUNTER) ==
                     csr_map_pkg::CSR_OFF_MCOUNTER;
  assign in_cnt_hi = (addr.raw & csr_map_pkg::CSR_MASK_MCOUNTER) ==
                     csr_map_pkg::CSR_OFF_MCOUNTERH;

  always_comb begin
    reg_sel_o = csr_map_pkg::SEL_NONE;
    known     = 1'b1;
    case (addr.raw)
      csr_map_pkg::CSR_MSTATUS:       reg_sel_o = csr_map_pkg::SEL_MSTATUS;
      csr_map_pkg::CSR_MISA:          reg_sel_o = csr_map_pkg::SEL_MISA;
      csr_map_pkg::CSR_MSCRATCH:      reg_sel_o = csr_map_pkg::SEL_MSCRATCH;
      csr_map_pkg::CSR_MEPC:          reg_sel_o = csr_map_pkg::SEL_MEPC;
      csr_map_pkg::CSR_MCAUSE:        reg_sel_o = csr_map_pkg::SEL_MCAUSE;
      csr_map_pkg::CSR_MTVAL:         reg_sel_o = csr_map_pkg::SEL_MTVAL;
      csr_map_pkg::CSR_MHARTID:       reg_sel_o = csr_map_pkg::SEL_MHARTID;
      csr_map_pkg::CSR_MCOUNTINHIBIT: reg_sel_o = csr_map_pkg::SEL_INHIBIT;
      default: begin
        // time slot has no counter behind it
        if ((in_cnt_lo || in_cnt_hi) && addr.f.index != 5'd1) begin
          // slots past the configured counters read as zero
          if (addr.f.index < CNT_LAST) begin
            reg_sel_o = csr_map_pkg::SEL_COUNTER;
          end
        end else begin
          known = 1'b0;
        end
      end
    endcase
  end

  assign is_write = csr_op_i != csr_map_pkg::CSR_OP_READ;

  // misa is a fixed constant here, so it behaves like a read-only address
  assign ro_write = is_write &&
                    (addr.f.access == 2'b11 || addr.raw == csr_map_pkg::CSR_MISA);

  assign illegal_o = csr_access_i && (!known || ro_write);
  assign wr_en_o   = csr_access_i && known && !ro_write && is_write;
  assign cnt_idx_o = addr.f.index;
  assign cnt_hi_o  = in_cnt_hi;

endmodule

`default_nettype wire

//--- csr_machine_regs.sv
/*
 * Machine trap state registers
 * Holds mstatus (MIE, MPIE), mscratch, mepc, mcause and mtval.
 * Trap entry and MRET update the state at the clock edge and take
 * precedence over a software write to the trap registers.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic [3:0]                          reg_sel_i,
  input  wire logic                                wr_en_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]      wdata_i,
  input  wire logic                                trap_save_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]      trap_pc_i,
  input  wire logic [csr_field_pkg::MCAUSE_W-1:0]  trap_cause_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]      trap_tval_i,
  input  wire logic                                mret_i,
  output logic                                     mie_o,
  output logic                                     mpie_o,
  output logic      [csr_field_pkg::XLEN-1:0]      mscratch_o,
  output logic      [csr_field_pkg::XLEN-1:0]      mepc_o,
  output logic      [csr_field_pkg::MCAUSE_W-1:0]  mcause_o,
  output logic      [csr_field_pkg::XLEN-1:0]      mtval_o
);

  localparam int unsigned XLEN = csr_field_pkg::XLEN;
  localparam int unsigned CW   = csr_field_pkg::MCAUSE_W;

  logic trap_evt;
  logic sw_trap_we;

  // trap entry or return blocks software updates of the trap registers
  assign trap_evt   = trap_save_i || mret_i;
  assign sw_trap_we = wr_en_i && !trap_evt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_o      <= 1'b0;
      mpie_o     <= 1'b0;
      mscratch_o <= '0;
      mepc_o     <= '0;
      mcause_o   <= '0;
      mtval_o    <= '0;
    end else begin
      if (wr_en_i && reg_sel_i == csr_map_pkg::SEL_MSCRATCH) begin
        mscratch_o <= wdata_i;
      end

      if (sw_trap_we) begin
        case (reg_sel_i)
          csr_map_pkg::SEL_MSTATUS: begin
            mie_o  <= wdata_i[csr_field_pkg::MSTATUS_MIE_BIT];
            mpie_o <= wdata_i[csr_field_pkg::MSTATUS_MPIE_BIT];
          end
          // halfword aligned with compressed instructions
          csr_map_pkg::SEL_MEPC:   mepc_o   <= {wdata_i[XLEN-1:1], 1'b0};
          csr_map_pkg::SEL_MCAUSE: mcause_o <= {wdata_i[XLEN-1], wdata_i[CW-2:0]};
          csr_map_pkg::SEL_MTVAL:  mtval_o  <= wdata_i;
          default: ;
        endcase
      end

      ////////////////////////////////////////////////////////////////////////
      // trap entry and return
      ////////////////////////////////////////////////////////////////////////

      if (trap_save_i) begin
        mpie_o   <= mie_o;
        mie_o    <= 1'b0;
        mepc_o   <= {trap_pc_i[XLEN-1:1], 1'b0};
        mcause_o <= trap_cause_i;
        mtval_o  <= trap_tval_i;
      end else if (mret_i) begin
        mie_o  <= mpie_o;
        mpie_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- csr_perf_counters.sv
/*
 * Performance counters
 * mcycle and minstret at 64 bits plus a configurable set of event
 * counters of configurable width, with mcountinhibit. Events are
 * hardwired per slot; absent slots read zero and are forced inhibited.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_perf_counters #(
  parameter int unsigned MHPM_COUNTER_NUM   = 4,
  parameter int unsigned MHPM_COUNTER_WIDTH = 40
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic [3:0]                     reg_sel_i,
  input  wire logic [4:0]                     cnt_idx_i,
  input  wire logic                           cnt_hi_i,
  input  wire logic                           wr_en_i,
  input  wire logic [csr_field_pkg::XLEN-1:0] wdata_i,
  input  wire logic                           instr_ret_i,
  input  wire logic                           instr_ret_compressed_i,
  input  wire logic                           imiss_i,
  input  wire logic                           pc_set_i,
  input  wire logic                           jump_i,
  input  wire logic                           branch_i,
  input  wire logic                           branch_taken_i,
  input  wire logic                           mem_load_i,
  input  wire logic                           mem_store_i,
  input  wire logic                           lsu_busy_i,
  output logic      [csr_field_pkg::XLEN-1:0] cnt_rdata_o,
  output logic      [csr_field_pkg::XLEN-1:0] inhibit_rdata_o
);

  localparam int unsigned XLEN  = csr_field_pkg::XLEN;
  localparam int unsigned FW    = csr_field_pkg::CNT_FULL_W;
  localparam int unsigned SLOTS = csr_field_pkg::CNT_SLOTS;
  localparam int unsigned LAST  = csr_field_pkg::CNT_FIXED + MHPM_COUNTER_NUM;

  localparam logic [FW:0]     EVT_MASK_X  = (65'd1 << MHPM_COUNTER_WIDTH) - 65'd1;
  localparam logic [FW-1:0]   EVT_MASK    = EVT_MASK_X[FW-1:0];
  // inhibit reads as set for every slot without a counter
  localparam logic [XLEN-1:0] INH_FORCE   = {XLEN{1'b1}} << LAST;

  logic [SLOTS-1:0] incr;
  logic [XLEN-1:0]  inhibit_q;
  logic [XLEN-1:0]  inhibit_eff;
  logic [FW-1:0]    cnt_val [SLOTS];
  logic             cnt_we;

  assign cnt_we      = wr_en_i && reg_sel_i == csr_map_pkg::SEL_COUNTER;
  assign inhibit_eff = inhibit_q | INH_FORCE;

  // hardwired event per slot
  always_comb begin
    incr     = '0;
    incr[0]  = 1'b1;
    incr[2]  = instr_ret_i;
    incr[3]  = lsu_busy_i;
    // fetch stalls, not counting cycles where the PC is being redirected
    incr[4]  = imiss_i && !pc_set_i;
    incr[5]  = mem_load_i;
    incr[6]  = mem_store_i;
    incr[7]  = jump_i;
    incr[8]  = branch_i;
    incr[9]  = branch_taken_i;
    incr[10] = instr_ret_compressed_i;
  end

  // bit 1 is the time slot and never inhibits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (wr_en_i && reg_sel_i == csr_map_pkg::SEL_INHIBIT) begin
      inhibit_q <= {wdata_i[XLEN-1:2], 1'b0, wdata_i[0]};
    end
  end

  for (genvar i = 0; i < SLOTS; i++) begin : g_slot
    if (i == 0 || i == 2 || (i >= csr_field_pkg::CNT_FIXED && i < LAST)) begin : g_on
      localparam logic [FW-1:0] MASK = (i == 0 || i == 2) ? {FW{1'b1}} : EVT_MASK;

      logic [FW-1:0] cnt_q;
      logic          lo_we;
      logic          hi_we;

      assign lo_we = cnt_we && cnt_idx_i == 5'(i) && !cnt_hi_i;
      assign hi_we = cnt_we && cnt_idx_i == 5'(i) && cnt_hi_i;

      // a software write replaces one half and suppresses the increment
      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          cnt_q <= '0;
        end else if (lo_we) begin
          cnt_q[XLEN-1:0] <= wdata_i & MASK[XLEN-1:0];
        end else if (hi_we) begin
          cnt_q[FW-1:XLEN] <= wdata_i & MASK[FW-1:XLEN];
        end else if (incr[i] && !inhibit_eff[i]) begin
          cnt_q <= (cnt_q + FW'(1)) & MASK;
        end
      end

      assign cnt_val[i] = cnt_q;
    end else begin : g_off
      assign cnt_val[i] = '0;
    end
  end

  assign cnt_rdata_o     = cnt_hi_i ? cnt_val[cnt_idx_i][FW-1:XLEN]
                                    : cnt_val[cnt_idx_i][XLEN-1:0];
  assign inhibit_rdata_o = inhibit_eff;

endmodule

`default_nettype wire

//--- csr_result.sv
/*
 * CSR read data and write data
 * Builds the read layouts of mstatus, mcause, misa and mhartid, selects
 * the read word and merges it with the operand for set and clear.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_result (
  input  wire logic [3:0]                         reg_sel_i,
  input  wire logic [1:0]                         csr_op_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]     csr_wdata_i,
  input  wire logic [3:0]                         core_id_i,
  input  wire logic [5:0]                         cluster_id_i,
  input  wire logic                               mie_i,
  input  wire logic                               mpie_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]     mscratch_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]     mepc_i,
  input  wire logic [csr_field_pkg::MCAUSE_W-1:0] mcause_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]     mtval_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]     cnt_rdata_i,
  input  wire logic [csr_field_pkg::XLEN-1:0]     inhibit_rdata_i,
  output logic      [csr_field_pkg::XLEN-1:0]     rdata_o,
  output logic      [csr_field_pkg::XLEN-1:0]     wdata_o
);

  localparam int unsigned XLEN = csr_field_pkg::XLEN;
  localparam int unsigned CW   = csr_field_pkg::MCAUSE_W;

  logic [XLEN-1:0] mstatus_rd;
  logic [XLEN-1:0] mcause_rd;
  logic [XLEN-1:0] mhartid_rd;

  always_comb begin
    mstatus_rd = '0;
    mstatus_rd[csr_field_pkg::MSTATUS_MIE_BIT]      = mie_i;
    mstatus_rd[csr_field_pkg::MSTATUS_MPIE_BIT]     = mpie_i;
    // only machine mode exists
    mstatus_rd[csr_field_pkg::MSTATUS_MPP_LSB +: 2] = 2'b11;
  end

  assign mcause_rd  = {mcause_i[CW-1], {(XLEN-CW){1'b0}}, mcause_i[CW-2:0]};
  assign mhartid_rd = {21'b0, cluster_id_i, 1'b0, core_id_i};

  always_comb begin
    case (reg_sel_i)
      csr_map_pkg::SEL_MSTATUS:  rdata_o = mstatus_rd;
      csr_map_pkg::SEL_MISA:     rdata_o = csr_field_pkg::MISA_VALUE;
      csr_map_pkg::SEL_MSCRATCH: rdata_o = mscratch_i;
      csr_map_pkg::SEL_MEPC:     rdata_o = mepc_i;
      csr_map_pkg::SEL_MCAUSE:   rdata_o = mcause_rd;
      csr_map_pkg::SEL_MTVAL:    rdata_o = mtval_i;
      csr_map_pkg::SEL_MHARTID:  rdata_o = mhartid_rd;
      csr_map_pkg::SEL_INHIBIT:  rdata_o = inhibit_rdata_i;
      csr_map_pkg::SEL_COUNTER:  rdata_o = cnt_rdata_i;
      default:                   rdata_o = '0;
    endcase
  end

  // read-modify-write for set and clear
  always_comb begin
    case (csr_op_i)
      csr_map_pkg::CSR_OP_SET:   wdata_o = csr_wdata_i | rdata_o;
      csr_map_pkg::CSR_OP_CLEAR: wdata_o = ~csr_wdata_i & rdata_o;
      default:                   wdata_o = csr_wdata_i;
    endcase
  end

endmodule

`default_nettype wire

//--- csr_unit_top.sv
/*
 * Machine-mode CSR unit
 * Decode, trap state, performance counters and read/write data
 * for a small RV32 core. Every access completes in one cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_unit_top #(
  parameter int unsigned MHPM_COUNTER_NUM   = 4,
  parameter int unsigned MHPM_COUNTER_WIDTH = 40
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  // software access
  input  wire logic        csr_access_i,
  input  wire logic [11:0] csr_addr_i,
  input  wire logic [1:0]  csr_op_i,
  input  wire logic [31:0] csr_wdata_i,
  output logic      [31:0] csr_rdata_o,
  output logic             illegal_csr_o,
  // trap control
  input  wire logic        trap_save_i,
  input  wire logic [31:0] trap_pc_i,
  input  wire logic [5:0]  trap_cause_i,
  input  wire logic [31:0] trap_tval_i,
  input  wire logic        mret_i,
  output logic             irq_enable_o,
  output logic      [31:0] mepc_o,
  input  wire logic [3:0]  core_id_i,
  input  wire logic [5:0]  cluster_id_i,
  // counter events
  input  wire logic        instr_ret_i,
  input  wire logic        instr_ret_compressed_i,
  input  wire logic        imiss_i,
  input  wire logic        pc_set_i,
  input  wire logic        jump_i,
  input  wire logic        branch_i,
  input  wire logic        branch_taken_i,
  input  wire logic        mem_load_i,
  input  wire logic        mem_store_i,
  input  wire logic        lsu_busy_i
);

  logic [3:0]  reg_sel;
  logic [4:0]  cnt_idx;
  logic        cnt_hi;
  logic        wr_en;
  logic [31:0] wdata;
  logic        mpie;
  logic [31:0] mscratch;
  logic [5:0]  mcause;
  logic [31:0] mtval;
  logic [31:0] cnt_rdata;
  logic [31:0] inhibit_rdata;

  csr_decode #(
    .MHPM_COUNTER_NUM (MHPM_COUNTER_NUM)
  ) u_decode (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .reg_sel_o    (reg_sel),
    .cnt_idx_o    (cnt_idx),
    .cnt_hi_o     (cnt_hi),
    .wr_en_o      (wr_en),
    .illegal_o    (illegal_csr_o)
  );

  csr_machine_regs u_machine_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .reg_sel_i    (reg_sel),
    .wr_en_i      (wr_en),
    .wdata_i      (wdata),
    .trap_save_i  (trap_save_i),
    .trap_pc_i    (trap_pc_i),
    .trap_cause_i (trap_cause_i),
    .trap_tval_i  (trap_tval_i),
    .mret_i       (mret_i),
    .mie_o        (irq_enable_o),
    .mpie_o       (mpie),
    .mscratch_o   (mscratch),
    .mepc_o       (mepc_o),
    .mcause_o     (mcause),
    .mtval_o      (mtval)
  );

  csr_perf_counters #(
    .MHPM_COUNTER_NUM   (MHPM_COUNTER_NUM),
    .MHPM_COUNTER_WIDTH (MHPM_COUNTER_WIDTH)
  ) u_perf_counters (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .reg_sel_i              (reg_sel),
    .cnt_idx_i              (cnt_idx),
    .cnt_hi_i               (cnt_hi),
    .wr_en_i                (wr_en),
    .wdata_i                (wdata),
    .instr_ret_i            (instr_ret_i),
    .instr_ret_compressed_i (instr_ret_compressed_i),
    .imiss_i                (imiss_i),
    .pc_set_i               (pc_set_i),
    .jump_i                 (jump_i),
    .branch_i               (branch_i),
    .branch_taken_i         (branch_taken_i),
    .mem_load_i             (mem_load_i),
    .mem_store_i            (mem_store_i),
    .lsu_busy_i             (lsu_busy_i),
    .cnt_rdata_o            (cnt_rdata),
    .inhibit_rdata_o        (inhibit_rdata)
  );

  csr_result u_result (
    .reg_sel_i       (reg_sel),
    .csr_op_i        (csr_op_i),
    .csr_wdata_i     (csr_wdata_i),
    .core_id_i       (core_id_i),
    .cluster_id_i    (cluster_id_i),
    .mie_i           (irq_enable_o),
    .mpie_i          (mpie),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc_o),
    .mcause_i        (mcause),
    .mtval_i         (mtval),
    .cnt_rdata_i     (cnt_rdata),
    .inhibit_rdata_i (inhibit_rdata),
    .rdata_o         (csr_rdata_o),
    .wdata_o         (wdata)
  );

endmodule

`default_nettype wire

//--- csr_unit_sva.sv
/*
 * CSR unit assertions
 * Illegal flag qualification and the interrupt enable around trap
 * entry and MRET. Bound into csr_unit_top.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_unit_sva (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic csr_access_i,
  input wire logic illegal_csr_o,
  input wire logic trap_save_i,
  input wire logic mret_i,
  input wire logic irq_enable_o,
  input wire logic mpie_i
);

  illegal_needs_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni) illegal_csr_o |-> csr_access_i
  ) else $error("illegal_csr_o high without csr_access_i");

  // trap entry always masks interrupts
  trap_clears_mie: assert property (
    @(posedge clk_i) disable iff (!rst_ni) trap_save_i |=> !irq_enable_o
  ) else $error("irq_enable_o still high after trap save");

  mret_restores_mie: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mret_i && !trap_save_i) |=> irq_enable_o == $past(mpie_i)
  ) else $error("irq_enable_o does not match prior MPIE after mret");

endmodule

bind csr_unit_top csr_unit_sva u_sva (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .csr_access_i  (csr_access_i),
  .illegal_csr_o (illegal_csr_o),
  .trap_save_i   (trap_save_i),
  .mret_i        (mret_i),
  .irq_enable_o  (irq_enable_o),
  .mpie_i        (mpie)
);

`default_nettype wire

//--- csr_unit_tb.sv
/*
 * Testbench for the machine-mode CSR unit
 * Random software accesses, trap entry, MRET and counter events from a
 * fixed seed, checked every cycle against a reference model.
 */

`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

  localparam int unsigned CNT_NUM   = 4;
  localparam int unsigned CNT_WIDTH = 8;
  localparam int unsigned FIXED     = 3;
  localparam int          PERIOD    = 40;
  localparam int          N_TESTS   = 3000;
  // RV32I with C and X and an MXL of 1
  localparam logic [31:0] MISA_EXP   = 32'h4080_0104;
  localparam logic [31:0] INH_FORCED = 32'hFFFF_FFFF << (FIXED + CNT_NUM);

  logic        clk_i;
  logic        rst_ni;
  logic        csr_access_i;
  logic [11:0] csr_addr_i;
  logic [1:0]  csr_op_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        illegal_csr_o;
  logic        trap_save_i;
  logic [31:0] trap_pc_i;
  logic [5:0]  trap_cause_i;
  logic [31:0] trap_tval_i;
  logic        mret_i;
  logic        irq_enable_o;
  logic [31:0] mepc_o;
  logic [3:0]  core_id_i;
  logic [5:0]  cluster_id_i;
  // ret, lsu_busy, imiss, pc_set, load, store, jump, branch, taken, ret_c
  logic [9:0]  evt;

  // reference model state
  logic        m_mie;
  logic        m_mpie;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [5:0]  m_mcause;
  logic [31:0] m_mtval;
  logic [31:0] m_inhibit;
  logic [63:0] m_cnt [32];

  integer      seed;
  int          errors;
  int          checks;

  csr_unit_top #(
    .MHPM_COUNTER_NUM   (CNT_NUM),
    .MHPM_COUNTER_WIDTH (CNT_WIDTH)
  ) DUT (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .csr_access_i           (csr_access_i),
    .csr_addr_i             (csr_addr_i),
    .csr_op_i               (csr_op_i),
    .csr_wdata_i            (csr_wdata_i),
    .csr_rdata_o            (csr_rdata_o),
    .illegal_csr_o          (illegal_csr_o),
    .trap_save_i            (trap_save_i),
    .trap_pc_i              (trap_pc_i),
    .trap_cause_i           (trap_cause_i),
    .trap_tval_i            (trap_tval_i),
    .mret_i                 (mret_i),
    .irq_enable_o           (irq_enable_o),
    .mepc_o                 (mepc_o),
    .core_id_i              (core_id_i),
    .cluster_id_i           (cluster_id_i),
    .instr_ret_i            (evt[0]),
    .lsu_busy_i             (evt[1]),
    .imiss_i                (evt[2]),
    .pc_set_i               (evt[3]),
    .mem_load_i             (evt[4]),
    .mem_store_i            (evt[5]),
    .jump_i                 (evt[6]),
    .branch_i               (evt[7]),
    .branch_taken_i         (evt[8]),
    .instr_ret_compressed_i (evt[9])
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  // ends a run that stops making progress
  initial begin
    #((N_TESTS + 50) * PERIOD);
    $display("timeout: the test sequence did not complete in time");
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic is_counter(input logic [11:0] a);
    return ((a & 12'hFE0) == 12'hB00 || (a & 12'hFE0) == 12'hB80) && a[4:0] != 5'd1;
  endfunction

  function automatic logic addr_known(input logic [11:0] a);
    case (a)
      12'h300, 12'h301, 12'h340, 12'h341, 12'h342, 12'h343, 12'hF14, 12'h320: return 1'b1;
      default: return is_counter(a);
    endcase
  endfunction

  function automatic logic is_illegal(input logic [11:0] a, input logic [1:0] op);
    return !addr_known(a) || (op != 2'd0 && (a[11:10] == 2'b11 || a == 12'h301));
  endfunction

  function automatic logic slot_exists(input int s);
    return s == 0 || s == 2 || (s >= FIXED && s < FIXED + CNT_NUM);
  endfunction

  function automatic logic [63:0] slot_mask(input int s);
    return (s < FIXED) ? 64'hFFFF_FFFF_FFFF_FFFF : (64'd1 << CNT_WIDTH) - 64'd1;
  endfunction

  function automatic logic slot_event(input int s);
    case (s)
      0:       return 1'b1;
      2:       return evt[0];
      3:       return evt[1];
      4:       return evt[2] && !evt[3];
      5:       return evt[4];
      6:       return evt[5];
      7:       return evt[6];
      8:       return evt[7];
      9:       return evt[8];
      10:      return evt[9];
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] read_value(input logic [11:0] a);
    logic [63:0] c;
    c = m_cnt[a[4:0]];
    case (a)
      12'h300: return {19'b0, 2'b11, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
      12'h301: return MISA_EXP;
      12'h340: return m_mscratch;
      12'h341: return m_mepc;
      12'h342: return {m_mcause[5], 26'b0, m_mcause[4:0]};
      12'h343: return m_mtval;
      12'hF14: return (32'(cluster_id_i) << 5) | 32'(core_id_i);
      12'h320: return m_inhibit | INH_FORCED;
      default: return is_counter(a) ? (a[7] ? c[63:32] : c[31:0]) : 32'd0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks at the falling edge and model update for the next rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_outputs();
    if (csr_access_i) begin
      check_value("csr_rdata_o", csr_rdata_o, read_value(csr_addr_i));
    end
    check_value("illegal_csr_o", 32'(illegal_csr_o),
                32'(csr_access_i && is_illegal(csr_addr_i, csr_op_i)));
    check_value("irq_enable_o", 32'(irq_enable_o), 32'(m_mie));
    check_value("mepc_o", mepc_o, m_mepc);
  endtask

  task automatic model_step();
    logic [31:0] rd;
    logic [31:0] wv;
    logic        wr;
    logic [63:0] mask;
    logic [31:0] inh;
    rd = read_value(csr_addr_i);
    case (csr_op_i)
      2'd2:    wv = csr_wdata_i | rd;
      2'd3:    wv = ~csr_wdata_i & rd;
      default: wv = csr_wdata_i;
    endcase
    wr  = csr_access_i && csr_op_i != 2'd0 && !is_illegal(csr_addr_i, csr_op_i);
    inh = m_inhibit | INH_FORCED;
    // counters see the inhibit value from before this edge
    for (int s = 0; s < 32; s++) begin
      if (slot_exists(s)) begin
        mask = slot_mask(s);
        if (wr && is_counter(csr_addr_i) && csr_addr_i[4:0] == 5'(s)) begin
          if (csr_addr_i[7]) begin
            m_cnt[s][63:32] = wv & mask[63:32];
          end else begin
            m_cnt[s][31:0] = wv & mask[31:0];
          end
        end else if (slot_event(s) && !inh[s]) begin
          m_cnt[s] = (m_cnt[s] + 64'd1) & mask;
        end
      end
    end
    if (wr && csr_addr_i == 12'h340) begin
      m_mscratch = wv;
    end
    if (wr && csr_addr_i == 12'h320) begin
      m_inhibit = {wv[31:2], 1'b0, wv[0]};
    end
    if (trap_save_i) begin
      m_mpie   = m_mie;
      m_mie    = 1'b0;
      m_mepc   = {trap_pc_i[31:1], 1'b0};
      m_mcause = trap_cause_i;
      m_mtval  = trap_tval_i;
    end else if (mret_i) begin
      m_mie  = m_mpie;
      m_mpie = 1'b1;
    end else if (wr) begin
      case (csr_addr_i)
        12'h300: begin
          m_mie  = wv[3];
          m_mpie = wv[7];
        end
        12'h341: m_mepc   = {wv[31:1], 1'b0};
        12'h342: m_mcause = {wv[31], wv[4:0]};
        12'h343: m_mtval  = wv;
        default: ;
      endcase
    end
  endtask

  task automatic drive_random();
    logic [11:0] addr;
    case (rand_below(16))
      0:       addr = csr_map_pkg::CSR_MSTATUS;
      1:       addr = csr_map_pkg::CSR_MISA;
      2:       addr = csr_map_pkg::CSR_MSCRATCH;
      3:       addr = csr_map_pkg::CSR_MEPC;
      4:       addr = csr_map_pkg::CSR_MCAUSE;
      5:       addr = csr_map_pkg::CSR_MTVAL;
      6:       addr = csr_map_pkg::CSR_MHARTID;
      7:       addr = csr_map_pkg::CSR_MCOUNTINHIBIT;
      // includes the time slot and the empty slots
      8:       addr = 12'hB00 | 12'(rand_below(12));
      9:       addr = 12'hB80 | 12'(rand_below(12));
      10:      addr = csr_map_pkg::CSR_MCYCLE;
      11:      addr = csr_map_pkg::CSR_MINSTRET;
      12:      addr = csr_map_pkg::CSR_MCYCLEH;
      13:      addr = csr_map_pkg::CSR_MINSTRETH;
      14:      addr = 12'hB00 | 12'(FIXED + rand_below(CNT_NUM));
      default: addr = 12'(rand_below(4096));
    endcase
    csr_access_i <= rand_below(8) != 0;
    csr_addr_i   <= addr;
    csr_op_i     <= 2'(rand_below(4));
    csr_wdata_i  <= $random(seed);
    trap_save_i  <= rand_below(12) == 0;
    mret_i       <= rand_below(12) == 0;
    trap_pc_i    <= $random(seed);
    trap_cause_i <= 6'(rand_below(64));
    trap_tval_i  <= $random(seed);
    evt          <= 10'(rand_below(1024));
  endtask

  initial begin
    seed         = 32'hf224095f;
    errors       = 0;
    checks       = 0;
    rst_ni       = 1'b0;
    csr_access_i = 1'b0;
    csr_addr_i   = '0;
    csr_op_i     = '0;
    csr_wdata_i  = '0;
    trap_save_i  = 1'b0;
    trap_pc_i    = '0;
    trap_cause_i = '0;
    trap_tval_i  = '0;
    mret_i       = 1'b0;
    evt          = '0;
    core_id_i    = 4'(rand_below(16));
    cluster_id_i = 6'(rand_below(64));
    m_mie        = 1'b0;
    m_mpie       = 1'b0;
    m_mscratch   = '0;
    m_mepc       = '0;
    m_mcause     = '0;
    m_mtval      = '0;
    m_inhibit    = '0;
    for (int s = 0; s < 32; s++) begin
      m_cnt[s] = '0;
    end

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int t = 0; t < N_TESTS; t++) begin
      @(negedge clk_i);
      check_outputs();
      model_step();
      @(posedge clk_i);
      drive_random();
    end
    @(negedge clk_i);
    check_outputs();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
csr_map_pkg.sv
csr_field_pkg.sv
csr_decode.sv
csr_machine_regs.sv
csr_perf_counters.sv
csr_result.sv
csr_unit_top.sv
csr_unit_sva.sv
csr_unit_tb.sv

//--- Makefile
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
